//--- common/frontend_macros.svh
`ifndef FRONTEND_MACROS_SVH
`define FRONTEND_MACROS_SVH

////////////////////////////////////////
// widths
////////////////////////////////////////

`define XLEN 32                      // data and address width

////////////////////////////////////////
// fetch and buffer
////////////////////////////////////////

`define RESET_PC 32'h1c000000        // first fetch address out of reset
`define IBUF_DEPTH 8                 // default instruction buffer entries

////////////////////////////////////////
// direct branch major opcodes, ir[31:26]
////////////////////////////////////////

`define OPC_B  6'b010100
`define OPC_BL 6'b010101

`endif

//--- common/frontend_pkg.sv
`include "frontend_macros.svh"

package frontend_pkg;

    ////////////////////////////////////////
    // basic words
    ////////////////////////////////////////

    // byte address
    typedef logic [`XLEN-1:0] addr_t;

    // one instruction word
    typedef logic [`XLEN-1:0] word_t;

    // aligned pair from imem, lower address in the low half
    typedef logic [2*`XLEN-1:0] pair_t;

    ////////////////////////////////////////
    // buffer entry
    ////////////////////////////////////////

    typedef struct packed {
        addr_t pc;   // address of the instruction
        word_t ir;   // raw encoding
    } fetch_entry_t;

endpackage

//--- fetch/pc_gen.sv
`timescale 1ns/1ps
`include "frontend_macros.svh"

module pc_gen (
    input  logic                 clk,
    input  logic                 i_rst_n,
    input  logic                 i_redirect,
    input  frontend_pkg::addr_t  i_redirect_pc,
    input  logic                 i_resp_take,
    input  frontend_pkg::addr_t  i_next_pc,
    output frontend_pkg::addr_t  o_fetch_pc
);

    logic [`XLEN-1:0] pc_q;
    logic [`XLEN-1:0] pc_d;

    // redirect from the back end beats the predecoder
    always_comb begin
        pc_d = pc_q;
        if (i_redirect) begin
            pc_d = i_redirect_pc;
        end else if (i_resp_take) begin
            pc_d = i_next_pc;   // sequential pair or branch target
        end
    end

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            pc_q <= `RESET_PC;
        end else begin
            pc_q <= pc_d;
        end
    end

    assign o_fetch_pc = pc_q;

    ////////////////////////////////////////
    // checks
    ////////////////////////////////////////

    // both redirect and predecoder targets must land on a word
    a_pc_aligned : assert property (
        @(posedge clk) disable iff (!i_rst_n)
        o_fetch_pc[1:0] == 2'b00
    ) else $error("fetch pc %h is not word aligned", o_fetch_pc);

endmodule

//--- fetch/fetch_ctrl.sv
`timescale 1ns/1ps

module fetch_ctrl (
    input  logic                 clk,
    input  logic                 i_rst_n,
    input  frontend_pkg::addr_t  i_fetch_pc,
    input  logic                 i_has_room,
    input  logic                 i_redirect,
    output logic                 o_imem_req,
    output frontend_pkg::addr_t  o_imem_addr,
    input  logic                 i_imem_valid,
    output logic                 o_resp_take
);

    logic outstanding_q;   // a request is in flight
    logic stale_q;         // in-flight request was overtaken by a redirect

    ////////////////////////////////////////
    // request side
    ////////////////////////////////////////

    // the pc is about to change on a redirect, so hold off that cycle
    assign o_imem_req  = !outstanding_q && i_has_room && !i_redirect;
    assign o_imem_addr = {i_fetch_pc[31:3], 3'b000};   // pair aligned

    ////////////////////////////////////////
    // response side
    ////////////////////////////////////////

    // a response in a redirect cycle belongs to the old path as well
    assign o_resp_take = outstanding_q && i_imem_valid && !stale_q && !i_redirect;

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            outstanding_q <= 1'b0;
        end else begin
            if (i_imem_valid) begin
                outstanding_q <= 1'b0;
            end
            if (o_imem_req) begin
                outstanding_q <= 1'b1;
            end
        end
    end

    // stale lives until the matching response is dropped
    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            stale_q <= 1'b0;
        end else if (i_imem_valid) begin
            stale_q <= 1'b0;
        end else if (i_redirect && outstanding_q) begin
            stale_q <= 1'b1;
        end
    end

    ////////////////////////////////////////
    // checks
    ////////////////////////////////////////

    // no second request while the memory still owes an answer
    a_one_outstanding : assert property (
        @(posedge clk) disable iff (!i_rst_n)
        (outstanding_q && !i_imem_valid) |=> !o_imem_req
    ) else $error("imem request issued while one is outstanding");

    // the memory only answers what was asked
    a_no_spurious_resp : assert property (
        @(posedge clk) disable iff (!i_rst_n)
        i_imem_valid |-> outstanding_q
    ) else $error("imem response without a request");

endmodule

//--- design/predecoder.sv
`timescale 1ns/1ps
`include "frontend_macros.svh"

module predecoder (
    input  frontend_pkg::addr_t         i_fetch_pc,
    input  frontend_pkg::pair_t         i_rdata,
    output frontend_pkg::fetch_entry_t  o_entry0,
    output frontend_pkg::fetch_entry_t  o_entry1,
    output logic [1:0]                  o_valid,
    output frontend_pkg::addr_t         o_next_pc
);

    import frontend_pkg::*;

    addr_t pair_pc;
    addr_t pc0;
    addr_t pc1;
    word_t ir0;
    word_t ir1;
    logic  br0;            // slot 0 holds a taken direct branch
    logic  br1;
    addr_t tgt0;
    addr_t tgt1;

    // B and BL only, both always taken
    function automatic logic is_direct(input word_t ir);
        return (ir[31:26] == `OPC_B) || (ir[31:26] == `OPC_BL);
    endfunction

    // offs26 = {ir[9:0], ir[25:10]}, word offset
    function automatic addr_t br_target(input addr_t pc, input word_t ir);
        logic [25:0] offs;
        offs = {ir[9:0], ir[25:10]};
        return pc + {{4{offs[25]}}, offs, 2'b00};
    endfunction

    ////////////////////////////////////////
    // slot decode
    ////////////////////////////////////////

    assign pair_pc = {i_fetch_pc[31:3], 3'b000};
    assign pc0     = pair_pc;
    assign pc1     = {i_fetch_pc[31:3], 3'b100};
    assign ir0     = i_rdata[31:0];                 // low half is the lower address
    assign ir1     = i_rdata[63:32];

    assign br0  = !i_fetch_pc[2] && is_direct(ir0);   // slot 0 skipped on odd entry
    assign br1  = is_direct(ir1);
    assign tgt0 = br_target(pc0, ir0);
    assign tgt1 = br_target(pc1, ir1);

    assign o_valid[0] = !i_fetch_pc[2];
    assign o_valid[1] = !br0;   // shadow of a taken branch

    assign o_entry0 = '{pc: pc0, ir: ir0};
    assign o_entry1 = '{pc: pc1, ir: ir1};

    // first taken branch wins, else fall through to the next pair
    always_comb begin
        if (br0) begin
            o_next_pc = tgt0;
        end else if (br1) begin
            o_next_pc = tgt1;
        end else begin
            o_next_pc = pair_pc + 32'd8;
        end
    end

endmodule

//--- ibuf/inst_buffer.sv
`timescale 1ns/1ps
`include "frontend_macros.svh"

module inst_buffer #(
    parameter int DEPTH = `IBUF_DEPTH   // power of two, 4 or more
) (
    input  logic                         clk,
    input  logic                         i_rst_n,
    input  logic                         i_flush,
    input  logic [1:0]                   i_push,
    input  frontend_pkg::fetch_entry_t   i_entry0,
    input  frontend_pkg::fetch_entry_t   i_entry1,
    input  logic                         i_stall,
    output logic                         o_inst_valid,
    output frontend_pkg::addr_t          o_inst_pc,
    output frontend_pkg::word_t          o_inst_ir,
    output logic                         o_has_room
);

    import frontend_pkg::*;

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = PTR_W + 1;

    fetch_entry_t mem [DEPTH];

    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic [PTR_W-1:0] wr_ptr1;   // slot 1 lands here
    logic [1:0]       n_push;
    logic             pop;

    ////////////////////////////////////////
    // head and status
    ////////////////////////////////////////

    assign o_inst_valid = (count_q != '0);
    assign o_inst_pc    = mem[rd_ptr_q].pc;
    assign o_inst_ir    = mem[rd_ptr_q].ir;
    assign o_has_room   = (count_q <= CNT_W'(DEPTH - 2));   // space for a full pair

    assign pop     = o_inst_valid && !i_stall;
    assign n_push  = {1'b0, i_push[0]} + {1'b0, i_push[1]};
    assign wr_ptr1 = wr_ptr_q + PTR_W'(i_push[0]);   // packs after slot 0 if present

    ////////////////////////////////////////
    // storage
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (i_push[0]) begin
            mem[wr_ptr_q] <= i_entry0;
        end
        if (i_push[1]) begin
            mem[wr_ptr1] <= i_entry1;
        end
    end

    ////////////////////////////////////////
    // pointers and count
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!i_rst_n || i_flush) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            wr_ptr_q <= wr_ptr_q + PTR_W'(n_push);
            if (pop) begin
                rd_ptr_q <= rd_ptr_q + PTR_W'(1);
            end
            count_q <= count_q + CNT_W'(n_push) - CNT_W'(pop);
        end
    end

    ////////////////////////////////////////
    // checks
    ////////////////////////////////////////

    a_count_bound : assert property (
        @(posedge clk) disable iff (!i_rst_n)
        count_q <= CNT_W'(DEPTH)
    ) else $error("instruction buffer count %0d over depth", count_q);

    // fetch only asks when there is room, and pops only add to it meanwhile
    a_push_room : assert property (
        @(posedge clk) disable iff (!i_rst_n)
        (|i_push) |-> o_has_room
    ) else $error("push into instruction buffer without room");

endmodule

//--- design/frontend_top.sv
`timescale 1ns/1ps

module frontend_top (
    input  logic                 clk,
    input  logic                 i_rst_n,
    // back end redirect
    input  logic                 i_redirect,
    input  frontend_pkg::addr_t  i_redirect_pc,
    // instruction memory
    output logic                 o_imem_req,
    output frontend_pkg::addr_t  o_imem_addr,
    input  logic                 i_imem_valid,
    input  frontend_pkg::pair_t  i_imem_rdata,
    // consumer
    input  logic                 i_stall,
    output logic                 o_inst_valid,
    output frontend_pkg::addr_t  o_inst_pc,
    output frontend_pkg::word_t  o_inst_ir
);

    import frontend_pkg::*;

    addr_t        fetch_pc;
    addr_t        next_pc;
    logic         resp_take;
    logic         has_room;
    fetch_entry_t pd_entry0;
    fetch_entry_t pd_entry1;
    logic [1:0]   pd_valid;
    logic [1:0]   push;

    ////////////////////////////////////////
    // fetch
    ////////////////////////////////////////

    pc_gen u_pc_gen (
        .clk           (clk),
        .i_rst_n       (i_rst_n),
        .i_redirect    (i_redirect),
        .i_redirect_pc (i_redirect_pc),
        .i_resp_take   (resp_take),
        .i_next_pc     (next_pc),
        .o_fetch_pc    (fetch_pc)
    );

    fetch_ctrl u_fetch_ctrl (
        .clk          (clk),
        .i_rst_n      (i_rst_n),
        .i_fetch_pc   (fetch_pc),
        .i_has_room   (has_room),
        .i_redirect   (i_redirect),
        .o_imem_req   (o_imem_req),
        .o_imem_addr  (o_imem_addr),
        .i_imem_valid (i_imem_valid),
        .o_resp_take  (resp_take)
    );

    ////////////////////////////////////////
    // predecode and buffer
    ////////////////////////////////////////

    predecoder u_predecoder (
        .i_fetch_pc (fetch_pc),
        .i_rdata    (i_imem_rdata),
        .o_entry0   (pd_entry0),
        .o_entry1   (pd_entry1),
        .o_valid    (pd_valid),
        .o_next_pc  (next_pc)
    );

    assign push = pd_valid & {2{resp_take}};   // only accepted responses go in

    inst_buffer u_inst_buffer (
        .clk          (clk),
        .i_rst_n      (i_rst_n),
        .i_flush      (i_redirect),
        .i_push       (push),
        .i_entry0     (pd_entry0),
        .i_entry1     (pd_entry1),
        .i_stall      (i_stall),
        .o_inst_valid (o_inst_valid),
        .o_inst_pc    (o_inst_pc),
        .o_inst_ir    (o_inst_ir),
        .o_has_room   (has_room)
    );

endmodule

//--- tests/tb_frontend.sv
`timescale 1ns/1ps
`include "frontend_macros.svh"

module tb_frontend;

    import frontend_pkg::*;

    localparam addr_t      BR_PC     = `RESET_PC + 32'h40;    // slot 0 of its pair
    localparam addr_t      BR_TARGET = `RESET_PC + 32'h200;
    localparam logic [5:0] FILL_OPC  = 6'b001010;            // not a branch
    localparam int         N_FIRST   = 40;                   // pops before any redirect
    localparam int         N_EACH    = 30;                   // pops after each redirect
    localparam int         N_REDIR   = 4;
    localparam int         N_TOTAL   = N_FIRST + N_REDIR * N_EACH;

    logic  clk = 1'b0;
    logic  i_rst_n = 1'b0;
    logic  i_redirect = 1'b0;
    addr_t i_redirect_pc = '0;
    logic  i_imem_valid = 1'b0;
    pair_t i_imem_rdata = '0;
    logic  i_stall = 1'b0;
    logic  o_imem_req;
    addr_t o_imem_addr;
    logic  o_inst_valid;
    addr_t o_inst_pc;
    word_t o_inst_ir;

    integer seed = 32'h19b15b77;
    int     errors = 0;
    int     pop_count = 0;
    int     br_hits = 0;
    int     stall_len = 0;
    logic   stall_en = 1'b0;
    addr_t  redir_tab [N_REDIR];

    // memory model state
    logic       mem_busy = 1'b0;
    logic [2:0] wait_cnt = '0;
    addr_t      req_addr = '0;

    // reference model of the front end
    logic  pend = 1'b0;         // request in flight
    logic  pend_stale = 1'b0;   // overtaken by a redirect
    addr_t m_fetch_pc = `RESET_PC;
    addr_t exp_pc = `RESET_PC;
    int    occ = 0;             // entries held in the buffer
    logic  take;
    logic  pop;

    frontend_top DUT (
        .clk           (clk),
        .i_rst_n       (i_rst_n),
        .i_redirect    (i_redirect),
        .i_redirect_pc (i_redirect_pc),
        .o_imem_req    (o_imem_req),
        .o_imem_addr   (o_imem_addr),
        .i_imem_valid  (i_imem_valid),
        .i_imem_rdata  (i_imem_rdata),
        .i_stall       (i_stall),
        .o_inst_valid  (o_inst_valid),
        .o_inst_pc     (o_inst_pc),
        .o_inst_ir     (o_inst_ir)
    );

    always #10 clk = ~clk;

    ////////////////////////////////////////
    // memory contents and fetch rules
    ////////////////////////////////////////

    function automatic word_t word_at(input addr_t a);
        logic [25:0] offs;
        offs = 26'((BR_TARGET - BR_PC) >> 2);
        if (a == BR_PC) begin
            return {`OPC_B, offs[15:0], offs[25:16]};   // the one table entry
        end
        return {FILL_OPC, a[27:2]};
    endfunction

    function automatic addr_t next_fetch_pc(input addr_t f);
        if ({f[31:3], 3'b000} == BR_PC && !f[2]) begin
            return BR_TARGET;
        end
        return {f[31:3], 3'b000} + 32'd8;
    endfunction

    // slot after a taken branch is dropped
    function automatic int slots_pushed(input addr_t f);
        if ({f[31:3], 3'b000} == BR_PC && !f[2]) begin
            return 1;
        end
        return f[2] ? 1 : 2;
    endfunction

    task automatic report_mismatch(input string what, input addr_t got, input addr_t exp);
        errors = errors + 1;
        $display("** Error at %0d ns: %s is %h, expected %h", $time, what, got, exp);
    endtask

    ////////////////////////////////////////
    // instruction memory, 1 to 5 cycles
    ////////////////////////////////////////

    always @(posedge clk) begin
        if (!i_rst_n) begin
            mem_busy     <= 1'b0;
            wait_cnt     <= '0;
            i_imem_valid <= 1'b0;
        end else begin
            i_imem_valid <= 1'b0;
            if (mem_busy) begin
                if (wait_cnt == 3'd0) begin
                    i_imem_valid <= 1'b1;
                    i_imem_rdata <= {word_at(req_addr + 32'd4), word_at(req_addr)};
                    mem_busy     <= 1'b0;
                end else begin
                    wait_cnt <= wait_cnt - 3'd1;
                end
            end else if (o_imem_req) begin
                mem_busy <= 1'b1;
                req_addr <= o_imem_addr;
                wait_cnt <= 3'($unsigned($random(seed)) % 5);
            end
        end
    end

    // stall in long random stretches
    always @(posedge clk) begin
        if (!i_rst_n || !stall_en) begin
            i_stall   <= 1'b0;
            stall_len <= 0;
        end else if (stall_len == 0) begin
            i_stall   <= 1'($random(seed));
            stall_len <= 4 + int'($unsigned($random(seed)) % 24);
        end else begin
            stall_len <= stall_len - 1;
        end
    end

    ////////////////////////////////////////
    // reference model
    ////////////////////////////////////////

    assign take = i_imem_valid && !pend_stale && !i_redirect;
    assign pop  = o_inst_valid && !i_stall;

    always @(posedge clk) begin
        if (!i_rst_n) begin
            pend       <= 1'b0;
            pend_stale <= 1'b0;
            m_fetch_pc <= `RESET_PC;
            exp_pc     <= `RESET_PC;
            occ        <= 0;
        end else begin
            if (o_imem_req) begin
                pend <= 1'b1;
            end else if (i_imem_valid) begin
                pend <= 1'b0;
            end
            if (i_imem_valid) begin
                pend_stale <= 1'b0;
            end else if (i_redirect && pend) begin
                pend_stale <= 1'b1;
            end
            if (i_redirect) begin
                m_fetch_pc <= i_redirect_pc;
                exp_pc     <= i_redirect_pc;
                occ        <= 0;   // whole buffer flushed
            end else begin
                if (take) begin
                    m_fetch_pc <= next_fetch_pc(m_fetch_pc);
                end
                if (pop) begin
                    exp_pc <= (exp_pc == BR_PC) ? BR_TARGET : exp_pc + 32'd4;
                end
                occ <= occ + (take ? slots_pushed(m_fetch_pc) : 0) - (pop ? 1 : 0);
            end
            if (pop) begin
                pop_count <= pop_count + 1;
            end
            if (pop && o_inst_pc == BR_PC) begin
                br_hits <= br_hits + 1;
            end
        end
    end

    ////////////////////////////////////////
    // checks
    ////////////////////////////////////////

    a_pc_order : assert property (@(posedge clk) disable iff (!i_rst_n)
        pop |-> o_inst_pc == exp_pc
    ) else report_mismatch("delivered pc", o_inst_pc, exp_pc);

    a_ir_match : assert property (@(posedge clk) disable iff (!i_rst_n)
        pop |-> o_inst_ir == word_at(o_inst_pc)
    ) else report_mismatch("delivered ir", o_inst_ir, word_at(o_inst_pc));

    a_no_shadow : assert property (@(posedge clk) disable iff (!i_rst_n)
        o_inst_valid |-> o_inst_pc != BR_PC + 32'd4
    ) else report_mismatch("pc after taken branch", o_inst_pc, BR_TARGET);

    a_req_addr : assert property (@(posedge clk) disable iff (!i_rst_n)
        o_imem_req |-> o_imem_addr == {m_fetch_pc[31:3], 3'b000}
    ) else report_mismatch("imem address", o_imem_addr, {m_fetch_pc[31:3], 3'b000});

    a_req_room : assert property (@(posedge clk) disable iff (!i_rst_n)
        o_imem_req |-> occ <= `IBUF_DEPTH - 2
    ) else report_mismatch("buffer entries at request", 32'(occ), `IBUF_DEPTH - 2);

    a_valid_occ : assert property (@(posedge clk) disable iff (!i_rst_n)
        o_inst_valid == (occ != 0)
    ) else report_mismatch("inst valid", 32'(o_inst_valid), 32'(occ != 0));

    ////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////

    task automatic wait_pops(input int n);
        int target;
        target = pop_count + n;
        while (pop_count < target) begin
            @(posedge clk);
        end
    endtask

    task automatic wait_mem_busy();
        while (!mem_busy) begin
            @(posedge clk);
        end
    endtask

    task automatic send_redirect(input addr_t pc);
        i_redirect    <= 1'b1;
        i_redirect_pc <= pc;
        @(posedge clk);
        i_redirect    <= 1'b0;
    endtask

    initial begin
        redir_tab[0] = `RESET_PC + 32'h1000;
        redir_tab[1] = `RESET_PC + 32'h2004;   // enters on slot 1
        redir_tab[2] = `RESET_PC + 32'h20;     // runs into the branch again
        redir_tab[3] = `RESET_PC + 32'h8000 + ((32'($random(seed)) & 32'h3ff) << 2);

        repeat (5) @(posedge clk);
        i_rst_n <= 1'b1;
        wait_pops(N_FIRST);

        stall_en <= 1'b1;
        for (int i = 0; i < N_REDIR; i++) begin
            if (i % 2 == 1) begin
                wait_mem_busy();   // hit a request in flight
            end
            send_redirect(redir_tab[i]);
            wait_pops(N_EACH);
        end
        repeat (4) @(posedge clk);

        if (br_hits < 2) begin
            $display("the branch at %h was delivered %0d times, expected at least 2",
                     BR_PC, br_hits);
        end
        $display("errors: %0d, branch passes: %0d, instructions delivered: %0d",
                 errors, br_hits, pop_count);
        if (errors == 0 && br_hits >= 2) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    // watchdog
    initial begin
        repeat (N_TOTAL * 40) @(posedge clk);
        $display("timeout: only %0d of %0d instructions delivered", pop_count, N_TOTAL);
        $display("Verification failed");
        $finish;
    end

endmodule

//--- src.f
+incdir+common
common/frontend_pkg.sv
fetch/pc_gen.sv
fetch/fetch_ctrl.sv
design/predecoder.sv
ibuf/inst_buffer.sv
design/frontend_top.sv
tests/tb_frontend.sv

//--- Makefile
# Verilator build and run of the fetch front end

VERILATOR  ?= verilator
TOP        ?= tb_frontend
LINT_TOP   ?= frontend_top
FILELIST   ?= src.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing
FAIL_MSG   ?= Verification failed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation reported a failure, see $(LOG)"; exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(LINT_TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
